// File: all.f
+incdir+source
source/dataflowPkg.sv
source/stageControl.sv
source/functionStage.sv
source/memoryStage.sv
source/executeUnit.sv
bench/executeUnit_checker.sv
bench/executeUnitTb.sv

// File: bench/executeUnitTb.sv
`timescale 1ns/1ps

module executeUnitTb;
    import dataflowPkg::*;

    localparam int MAX_ENTRIES = 32;
    localparam int WAIT_LIMIT  = 40;

    logic     CP;
    logic     MR;
    logic     DEL;
    logic     Send_in;
    logic     Ack_in;
    packetIn  PACKET_IN;
    logic     Send_out;
    logic     Ack_out;
    packetOut PACKET_OUT;

    // Stimulus table
    packetIn  inTab   [0:MAX_ENTRIES-1];
    packetOut outTab  [0:MAX_ENTRIES-1];
    logic     emitTab [0:MAX_ENTRIES-1];
    logic     delTab  [0:MAX_ENTRIES-1];
    int       numEntries;

    packetOut expQ [$];
    int       outCount;
    int       errors;
    int       checks;
    logic     holdAck;
    logic     timedOut;
    integer   seed;

    executeUnit dut0
    (
        .CP         (CP),
        .MR         (MR),
        .DEL        (DEL),
        .Send_in    (Send_in),
        .Ack_in     (Ack_in),
        .PACKET_IN  (PACKET_IN),
        .Send_out   (Send_out),
        .Ack_out    (Ack_out),
        .PACKET_OUT (PACKET_OUT)
    );

    always #2 CP = ~CP;

    // cz is {C, Z}
    function automatic packetIn inPkt(tagWord t, logic [5:0] op, logic [1:0] cz,
                                      dataWord dl, dataWord dr);
        return {t, op, cz, dl, dr};
    endfunction

    function automatic packetOut outPkt(tagWord t, logic [1:0] cz, dataWord res);
        return {t, cz, res};
    endfunction

    task automatic addEntry(packetIn pin, packetOut pout, int emits, int del = 0);
        inTab[numEntries]   = pin;
        outTab[numEntries]  = pout;
        emitTab[numEntries] = (emits != 0);
        delTab[numEntries]  = (del != 0);
        numEntries++;
    endtask

    task automatic buildTable();
        tagWord t0;
        tagWord tF0;
        tagWord tBz;
        tagWord tCol;
        tagWord tG37;
        tagWord tG10;
        tagWord tG3b;
        t0   = {3'd5, 8'h3c, 7'h12, 2'b01, 1'b1, 1'b0};
        tF0  = {3'd5, 8'hf0, 7'h12, 2'b01, 1'b1, 1'b0};
        tBz  = {3'd5, 8'h3c, 7'h13, 2'b10, 1'b1, 1'b0};
        tCol = {3'd2, 8'h3c, 7'h12, 2'b01, 1'b1, 1'b0};
        tG37 = {3'd5, 8'h37, 7'h12, 2'b01, 1'b1, 1'b0};
        tG10 = {3'd5, 8'h10, 7'h12, 2'b01, 1'b1, 1'b0};
        tG3b = {3'd5, 8'h3b, 7'h12, 2'b01, 1'b1, 1'b0};
        addEntry(inPkt(t0, opAdd, 2'b00, 16'h1234, 16'h0101), outPkt(t0, 2'b00, 16'h1335), 1);
        addEntry(inPkt(t0, opAdd, 2'b00, 16'hffff, 16'h0001), outPkt(t0, 2'b11, 16'h0000), 1);
        addEntry(inPkt(t0, opAdd, 2'b00, 16'h8000, 16'h8001), outPkt(t0, 2'b10, 16'h0001), 1);
        addEntry(inPkt(t0, opSub, 2'b11, 16'h0005, 16'h0003), outPkt(t0, 2'b00, 16'h0002), 1);
        addEntry(inPkt(t0, opSub, 2'b00, 16'h0003, 16'h0005), outPkt(t0, 2'b10, 16'hfffe), 1);
        addEntry(inPkt(t0, opSub, 2'b00, 16'h7777, 16'h7777), outPkt(t0, 2'b01, 16'h0000), 1);
        // Logic ops keep the incoming carry
        addEntry(inPkt(t0, opAnd, 2'b10, 16'hf0f0, 16'h0ff0), outPkt(t0, 2'b10, 16'h00f0), 1);
        addEntry(inPkt(t0, opOr, 2'b00, 16'h1200, 16'h0034), outPkt(t0, 2'b00, 16'h1234), 1);
        addEntry(inPkt(t0, opXor, 2'b10, 16'hffff, 16'hffff), outPkt(t0, 2'b11, 16'h0000), 1);
        addEntry(inPkt(t0, opMul, 2'b10, 16'h0012, 16'h0034), outPkt(t0, 2'b00, 16'h03a8), 1);
        addEntry(inPkt(t0, opMul, 2'b10, 16'h0100, 16'h0100), outPkt(t0, 2'b01, 16'h0000), 1);
        addEntry(inPkt(t0, opShl, 2'b10, 16'h0001, 16'h0004), outPkt(t0, 2'b00, 16'h0010), 1);
        addEntry(inPkt(t0, opShr, 2'b10, 16'h8000, 16'h000f), outPkt(t0, 2'b00, 16'h0001), 1);
        addEntry(inPkt(t0, opShr, 2'b00, 16'h0001, 16'h0001), outPkt(t0, 2'b01, 16'h0000), 1);
        // BZ taken then not taken
        addEntry(inPkt(t0, opBz, 2'b01, 16'hbeef, 16'h0001), outPkt(tBz, 2'b01, 16'hbeef), 1);
        addEntry(inPkt(t0, opBz, 2'b10, 16'hbeef, 16'h0001), outPkt(t0, 2'b10, 16'hbeef), 1);
        addEntry(inPkt(t0, opChgcol, 2'b00, 16'h4321, 16'h00fa), outPkt(tCol, 2'b00, 16'h4321), 1);
        addEntry(inPkt(t0, opAddgen, 2'b00, 16'h1111, 16'hfffb), outPkt(tG37, 2'b00, 16'h1111), 1);
        addEntry(inPkt(tF0, opAddgen, 2'b00, 16'h2222, 16'h0020), outPkt(tG10, 2'b00, 16'h2222), 1);
        addEntry(inPkt(t0, opDecgen, 2'b00, 16'h3333, 16'h0000), outPkt(tG3b, 2'b00, 16'h3333), 1);
        // Two store and load pairs, the second with an address above 8 bits
        addEntry(inPkt(t0, opStm, 2'b00, 16'hcafe, 16'h0042), outPkt(t0, 2'b00, 16'h0042), 1);
        addEntry(inPkt(t0, opLdm, 2'b00, 16'h0040, 16'h0002), outPkt(t0, 2'b00, 16'hcafe), 1);
        addEntry(inPkt(t0, opStm, 2'b00, 16'h1357, 16'h01a5), outPkt(t0, 2'b00, 16'h01a5), 1);
        addEntry(inPkt(t0, opLdm, 2'b00, 16'h0100, 16'h00a5), outPkt(t0, 2'b00, 16'h1357), 1);
        // Erased packets
        addEntry(inPkt(t0, opAbsorb, 2'b00, 16'h1234, 16'h5678), '0, 0);
        addEntry(inPkt(t0, opAddc, 2'b00, 16'h1234, 16'h5678), '0, 0);
        addEntry(inPkt(t0, 6'h3f, 2'b00, 16'h1234, 16'h5678), '0, 0);
        addEntry(inPkt(t0, opAdd, 2'b00, 16'h1234, 16'h5678), '0, 0, 1);
        addEntry(inPkt(t0, opAdd, 2'b00, 16'h0007, 16'h0008), outPkt(t0, 2'b00, 16'h000f), 1);
    endtask

    task automatic sendPacket(packetIn pin, logic del);
        int n;
        n = 0;
        @(posedge CP);
        PACKET_IN <= pin;
        Send_in   <= 1'b1;
        @(negedge CP);
        while (Ack_out !== 1'b1 && n < WAIT_LIMIT)
        begin
            @(negedge CP);
            n++;
        end
        if (Ack_out !== 1'b1)
        begin
            $display("Timeout: Ack_out did not rise for an offered packet");
            errors++;
            timedOut = 1'b1;
        end
        // DEL in the cycle after the transfer edge erases the held packet
        @(posedge CP);
        Send_in <= 1'b0;
        DEL     <= del;
        @(posedge CP);
        DEL <= 1'b0;
    endtask

    task automatic waitForOutput(int target);
        int n;
        n = 0;
        while (outCount < target && n < WAIT_LIMIT)
        begin
            @(negedge CP);
            n++;
        end
        if (outCount < target)
        begin
            $display("Timeout: result packet %0d never appeared on Send_out", target);
            errors++;
            timedOut = 1'b1;
        end
    endtask

    task automatic checkBackPressure();
        tagWord t;
        int     target;
        t = {3'd1, 8'h07, 7'h05, 2'b10, 1'b0, 1'b1};
        expQ.push_back(outPkt(t, 2'b00, 16'h0003));
        expQ.push_back(outPkt(t, 2'b00, 16'h0ff0));
        expQ.push_back(outPkt(t, 2'b00, 16'h000f));
        target  = outCount + 3;
        holdAck = 1'b1;
        sendPacket(inPkt(t, opAdd, 2'b00, 16'h0001, 16'h0002), 1'b0);
        sendPacket(inPkt(t, opOr, 2'b00, 16'h00f0, 16'h0f00), 1'b0);
        fork
            sendPacket(inPkt(t, opSub, 2'b00, 16'h0010, 16'h0001), 1'b0);
            begin
                // Both stages full
                repeat (6)
                begin
                    @(negedge CP);
                    checks++;
                    if (Ack_out !== 1'b0)
                    begin
                        $display("[ERROR] Ack_out: got %h, expected 0", Ack_out);
                        errors++;
                    end
                end
                holdAck = 1'b0;
            end
        join
        waitForOutput(target);
    endtask

    // Downstream model and scoreboard
    initial
    begin
        int       ackDelay;
        int       n;
        packetOut held;
        packetOut want;
        forever
        begin
            @(negedge CP);
            if (Send_out === 1'b1)
            begin
                held = PACKET_OUT;
                checks++;
                if (expQ.size() == 0)
                begin
                    $display("Unexpected packet %h on Send_out", held);
                    errors++;
                end
                else
                begin
                    want = expQ.pop_front();
                    if (held !== want)
                    begin
                        $display("[ERROR] PACKET_OUT: got %h, expected %h", held, want);
                        errors++;
                    end
                end
                outCount++;
                n = 0;
                while (holdAck && n < WAIT_LIMIT)
                begin
                    @(negedge CP);
                    n++;
                    checks++;
                    if (PACKET_OUT !== held)
                    begin
                        $display("[ERROR] PACKET_OUT: got %h, expected %h", PACKET_OUT, held);
                        errors++;
                    end
                end
                if (holdAck)
                begin
                    $display("Timeout: downstream stayed blocked");
                    errors++;
                    timedOut = 1'b1;
                end
                ackDelay = $unsigned($random(seed)) % 4;
                repeat (ackDelay) @(negedge CP);
                @(posedge CP);
                Ack_in <= 1'b1;
                @(posedge CP);
                Ack_in <= 1'b0;
            end
        end
    end

    initial
    begin
        int target;
        seed       = 32'h875c;
        CP         = 1'b0;
        MR         = 1'b1;
        DEL        = 1'b0;
        Send_in    = 1'b0;
        Ack_in     = 1'b0;
        PACKET_IN  = '0;
        holdAck    = 1'b0;
        timedOut   = 1'b0;
        errors     = 0;
        checks     = 0;
        outCount   = 0;
        numEntries = 0;
        buildTable();
        repeat (3) @(posedge CP);
        MR <= 1'b0;
        for (int i = 0; i < numEntries && !timedOut; i++)
        begin
            if (emitTab[i])
                expQ.push_back(outTab[i]);
            target = outCount + int'(emitTab[i]);
            sendPacket(inTab[i], delTab[i]);
            if (emitTab[i])
                waitForOutput(target);
            else
            begin
                repeat (12) @(negedge CP);
                checks++;
                if (outCount != target)
                begin
                    $display("Erased packet %0d still raised Send_out", i);
                    errors++;
                end
            end
        end
        if (!timedOut)
            checkBackPressure();
        errors += dut0.chk0.failCount;
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: bench/executeUnit_checker.sv
`timescale 1ns/1ps

module executeUnit_checker
(
    input logic                  CP,
    input logic                  MR,
    input logic                  DEL,
    input logic                  Send_in,
    input logic                  Ack_in,
    input logic                  Send_out,
    input logic                  Ack_out,
    input logic                  SendMid,
    input dataflowPkg::packetOut PACKET_OUT
);

    int failCount = 0;

    // Held result waits for downstream
    holdUntilAck: assert property (@(posedge CP) disable iff (MR)
        (Send_out && !Ack_in) |=> (Send_out && $stable(PACKET_OUT)))
    else
    begin
        failCount++;
        $error("Send_out or PACKET_OUT changed before Ack_in");
    end

    // Ack answers a Send, and the filled stage cannot ack again at once
    noAckWithoutSend: assert property (@(posedge CP) disable iff (MR)
        (Ack_out && !DEL) |-> (Send_in ##1 !Ack_out))
    else
    begin
        failCount++;
        $error("Ack_out without Send_in or on two cycles in a row");
    end

    // All stages empty once reset is released
    quietAfterReset: assert property (@(posedge CP)
        $fell(MR) |-> (!Send_out && !Ack_out && !SendMid))
    else
    begin
        failCount++;
        $error("Handshake output active right after reset");
    end

endmodule

bind executeUnit executeUnit_checker chk0
(
    .CP         (CP),
    .MR         (MR),
    .DEL        (DEL),
    .Send_in    (Send_in),
    .Ack_in     (Ack_in),
    .Send_out   (Send_out),
    .Ack_out    (Ack_out),
    .SendMid    (SendMid),
    .PACKET_OUT (PACKET_OUT)
);

// File: source/executeUnit.sv
`timescale 1ns/1ps

module executeUnit
(
    input  logic                  CP,
    input  logic                  MR,
    input  logic                  DEL,
    input  logic                  Send_in,
    input  logic                  Ack_in,
    input  dataflowPkg::packetIn  PACKET_IN,
    output logic                  Send_out,
    output logic                  Ack_out,
    output dataflowPkg::packetOut PACKET_OUT
);
    import dataflowPkg::*;

    logic     SendMid;
    logic     AckMid;
    logic     writeEn;
    logic     loadFlg;
    logic     absorb;
    dataWord  writeData;
    packetOut pktMid;

    functionStage fnStage0
    (
        .CP         (CP),
        .MR         (MR),
        .DEL        (DEL),
        .Send_in    (Send_in),
        .Ack_in     (AckMid),
        .PACKET_IN  (PACKET_IN),
        .Send_out   (SendMid),
        .Ack_out    (Ack_out),
        .WRITE_EN   (writeEn),
        .LOAD_FLG   (loadFlg),
        .absorb     (absorb),
        .WRITE_DATA (writeData),
        .PACKET_OUT (pktMid)
    );

    memoryStage memStage0
    (
        .CP         (CP),
        .MR         (MR),
        .Send_in    (SendMid),
        .Ack_in     (Ack_in),
        .WRITE_EN   (writeEn),
        .LOAD_FLG   (loadFlg),
        .absorb     (absorb),
        .WRITE_DATA (writeData),
        .PACKET_IN  (pktMid),
        .Send_out   (Send_out),
        .Ack_out    (AckMid),
        .PACKET_OUT (PACKET_OUT)
    );

endmodule

// File: source/memoryStage.sv
`timescale 1ns/1ps
`include "dataflow_settings.svh"

module memoryStage
(
    input  logic                 CP,
    input  logic                 MR,
    input  logic                 Send_in,
    input  logic                 Ack_in,
    input  logic                 WRITE_EN,
    input  logic                 LOAD_FLG,
    input  logic                 absorb,
    input  dataflowPkg::dataWord  WRITE_DATA,
    input  dataflowPkg::packetOut PACKET_IN,
    output logic                 Send_out,
    output logic                 Ack_out,
    output dataflowPkg::packetOut PACKET_OUT
);
    import dataflowPkg::*;

    logic     load;
    logic     drop;
    packetOut pktQ;
    logic     loadFlgQ;
    memAddr   wrAddr;
    memAddr   rdAddr;
    dataWord  mem [0:(1 << `MEM_ADDR_BITS)-1];

    // Erased packet is taken but the stage stays empty
    assign drop = absorb & load;

    stageControl ctl0
    (
        .CP       (CP),
        .MR       (MR),
        .Send_in  (Send_in),
        .Ack_in   (Ack_in),
        .Exb      (drop),
        .Ack_out  (Ack_out),
        .Send_out (Send_out),
        .load     (load)
    );

    always_ff @(posedge CP)
    begin
        if (load)
        begin
            pktQ     <= PACKET_IN;
            loadFlgQ <= LOAD_FLG;
        end
    end

    // STM address sits in the result field
    assign wrAddr = PACKET_IN[`MEM_ADDR_BITS-1:0];

    always_ff @(posedge CP)
    begin
        if (load && WRITE_EN)
        begin
            mem[wrAddr] <= WRITE_DATA;
        end
    end

    assign rdAddr = pktQ[`MEM_ADDR_BITS-1:0];

    // LDM result replaced by the memory word
    always_comb
    begin
        PACKET_OUT = pktQ;
        if (loadFlgQ)
        begin
            PACKET_OUT[`DATA_LENGTH-1:0] = mem[rdAddr];
        end
    end

endmodule

// File: source/functionStage.sv
`timescale 1ns/1ps
`include "dataflow_settings.svh"

module functionStage
(
    input  logic                CP,
    input  logic                MR,
    input  logic                DEL,
    input  logic                Send_in,
    input  logic                Ack_in,
    input  dataflowPkg::packetIn PACKET_IN,
    output logic                Send_out,
    output logic                Ack_out,
    output logic                WRITE_EN,
    output logic                LOAD_FLG,
    output logic                absorb,
    output dataflowPkg::dataWord WRITE_DATA,
    output dataflowPkg::packetOut PACKET_OUT
);
    import dataflowPkg::*;

    logic    load;
    packetIn dl;

    colorId  color;
    genId    gen;
    destNode dest;
    portSel  lr2;
    logic    br;
    logic    cpy;
    opcode   opc;
    logic    cIn;
    logic    zIn;
    dataWord dataL;
    dataWord dataR;

    tagWord  tagOut;
    logic    cOut;
    logic    zOut;
    dataWord result;

    stageControl ctl0
    (
        .CP       (CP),
        .MR       (MR),
        .Send_in  (Send_in),
        .Ack_in   (Ack_in),
        .Exb      (DEL),
        .Ack_out  (Ack_out),
        .Send_out (Send_out),
        .load     (load)
    );

    // Pipeline register
    always_ff @(posedge CP)
    begin
        if (load)
        begin
            dl <= PACKET_IN;
        end
    end

    assign color = dl[`IN_COLOR_LSB +: `color_LENGTH];
    assign gen   = dl[`IN_GEN_LSB +: `gen_LENGTH];
    assign dest  = dl[`IN_DEST_LSB +: `dest_LENGTH];
    assign lr2   = dl[`IN_LR2_LSB +: 2];
    assign br    = dl[`IN_BR_BIT];
    assign cpy   = dl[`IN_CPY_BIT];
    assign opc   = opcode'(dl[`IN_OPC_LSB +: `OPC_LENGTH]);
    assign cIn   = dl[`IN_C_BIT];
    assign zIn   = dl[`IN_Z_BIT];
    assign dataL = dl[`IN_DATAL_LSB +: `DATA_LENGTH];
    assign dataR = dl[`IN_DATAR_LSB +: `DATA_LENGTH];

    always_comb
    begin
        tagOut   = {color, gen, dest, lr2, br, cpy};
        cOut     = cIn;
        zOut     = zIn;
        result   = dataL;
        WRITE_EN = 1'b0;
        LOAD_FLG = 1'b0;
        absorb   = 1'b0;

        case (opc)
            opAdd:
            begin
                {cOut, result} = {1'b0, dataL} + {1'b0, dataR};
                zOut = ~|result;
            end
            opSub:
            begin
                result = dataL - dataR;
                // Borrow
                cOut = (dataL < dataR);
                zOut = ~|result;
            end
            opAnd, opOr, opXor:
            begin
                // Carry passes through
                case (opc)
                    opAnd:   result = dataL & dataR;
                    opOr:    result = dataL | dataR;
                    default: result = dataL ^ dataR;
                endcase
                zOut = ~|result;
            end
            opMul, opShl, opShr:
            begin
                case (opc)
                    opMul:   result = dataL * dataR;
                    opShl:   result = dataL << dataR;
                    default: result = dataL >> dataR;
                endcase
                cOut = 1'b0;
                zOut = ~|result;
            end
            opBz:
            begin
                // Taken branch moves to the next node and swaps the port pair
                if (zIn)
                begin
                    tagOut = {color, gen, destNode'(dest + 1'b1), lr2[0], lr2[1], br, cpy};
                end
            end
            opLdm:
            begin
                result   = dataL + dataR;
                LOAD_FLG = 1'b1;
            end
            opStm:
            begin
                // Result carries the store address
                result   = dataR;
                WRITE_EN = 1'b1;
            end
            opChgcol:
            begin
                tagOut = {dataR[`color_LENGTH-1:0], gen, dest, lr2, br, cpy};
            end
            opAddgen:
            begin
                tagOut = {color, genId'($signed(gen) + $signed(dataR)), dest, lr2, br, cpy};
            end
            opDecgen:
            begin
                tagOut = {color, genId'(gen - 1'b1), dest, lr2, br, cpy};
            end
            opAbsorb, opAddc, opSubc, opRol, opRor, opBnz, opBc, opBnc, opBzl, opBnzl:
            begin
                tagOut = '0;
                cOut   = 1'b0;
                zOut   = 1'b0;
                result = '0;
                absorb = 1'b1;
            end
            default:
            begin
                // Undefined encodings are erased too
                tagOut = '0;
                cOut   = 1'b0;
                zOut   = 1'b0;
                result = '0;
                absorb = 1'b1;
            end
        endcase
    end

    assign WRITE_DATA = dataL;
    assign PACKET_OUT = {tagOut, cOut, zOut, result};

endmodule

// File: source/stageControl.sv
`timescale 1ns/1ps

module stageControl
(
    input  logic CP,
    input  logic MR,
    input  logic Send_in,
    input  logic Ack_in,
    input  logic Exb,
    output logic Ack_out,
    output logic Send_out,
    output logic load
);

    logic full;
    logic take;

    // Accept only into an empty stage
    assign take = Send_in & ~full;

    assign Ack_out = take;
    assign load = take;

    // Exb hides the held packet from downstream
    assign Send_out = full & ~Exb;

    // Set on transfer in, cleared by downstream ack or by erase.
    // An erase in the loading cycle keeps the stage empty.
    always_ff @(posedge CP or posedge MR)
    begin
        if (MR)
        begin
            full <= 1'b0;
        end
        else if (Exb)
        begin
            full <= 1'b0;
        end
        else if (take)
        begin
            full <= 1'b1;
        end
        else if (Ack_in)
        begin
            full <= 1'b0;
        end
    end

endmodule

// File: source/dataflowPkg.sv
`include "dataflow_settings.svh"

package dataflowPkg;

    typedef logic [`DATA_LENGTH-1:0]       dataWord;
    typedef logic [`color_LENGTH-1:0]      colorId;
    // Signed only where ADDGEN uses it
    typedef logic [`gen_LENGTH-1:0]        genId;
    typedef logic [`dest_LENGTH-1:0]       destNode;
    typedef logic [1:0]                    portSel;

    // color, gen, dest, LR2, BR, CPY
    typedef logic [`TAG_LENGTH-1:0]        tagWord;

    typedef logic [`PACKET_IN_LENGTH-1:0]  packetIn;
    // tag, C, Z, result
    typedef logic [`PACKET_OUT_LENGTH-1:0] packetOut;

    typedef logic [`MEM_ADDR_BITS-1:0]     memAddr;

    typedef enum logic [`OPC_LENGTH-1:0] {
        opAdd    = 6'h00,
        opAddc   = 6'h01,
        opSub    = 6'h02,
        opSubc   = 6'h03,
        opAnd    = 6'h04,
        opOr     = 6'h05,
        opXor    = 6'h06,
        opMul    = 6'h07,
        opShl    = 6'h08,
        opShr    = 6'h09,
        opRol    = 6'h0A,
        opRor    = 6'h0B,
        opBz     = 6'h0C,
        opBnz    = 6'h0D,
        opBc     = 6'h0E,
        opBnc    = 6'h0F,
        opBzl    = 6'h10,
        opBnzl   = 6'h11,
        opLdm    = 6'h12,
        opStm    = 6'h13,
        opAbsorb = 6'h14,
        opChgcol = 6'h15,
        opAddgen = 6'h16,
        opDecgen = 6'h17
    } opcode;

endpackage

// File: source/dataflow_settings.svh
`ifndef DATAFLOW_SETTINGS_SVH
`define DATAFLOW_SETTINGS_SVH

// Field widths
`define DATA_LENGTH        16
`define color_LENGTH       3
`define gen_LENGTH         8
`define dest_LENGTH        7
`define OPC_LENGTH         6
`define TAG_LENGTH         22

// Whole packets
`define PACKET_IN_LENGTH   62
`define PACKET_OUT_LENGTH  40

// Data memory depth as a power of two
`define MEM_ADDR_BITS      8

// Input packet layout, LSB of each field
`define IN_DATAR_LSB       0
`define IN_DATAL_LSB       16
`define IN_Z_BIT           32
`define IN_C_BIT           33
`define IN_OPC_LSB         34
`define IN_CPY_BIT         40
`define IN_BR_BIT          41
`define IN_LR2_LSB         42
`define IN_DEST_LSB        44
`define IN_GEN_LSB         51
`define IN_COLOR_LSB       59

`endif
